//--- hw/coproc_pkg.sv
// Coprocessor package with frame sizes, address widths and shared bus types
package coproc_pkg;

	// Element and stream word widths
	localparam int data_width = 8;
	localparam int axis_width = 32;

	// Matrix shapes
	localparam int a_rows   = 64;
	localparam int a_cols   = 7;
	localparam int b_words  = 16;
	localparam int c_words  = 3;
	localparam int n_hidden = 2;

	// Frame word counts
	localparam int a_words   = a_rows * a_cols;
	localparam int in_words  = a_words + b_words + c_words;
	localparam int out_words = a_rows;

	// Address widths per memory
	localparam int a_addr_bits   = 9;
	localparam int b_addr_bits   = 4;
	localparam int c_addr_bits   = 2;
	localparam int res_addr_bits = 6;

	// Bias plus 7 full 8x8 products needs 19 bits
	localparam int acc_width  = 19;
	localparam int frac_shift = 8;

	typedef logic [data_width-1:0] elem_t;

	// One write request, each memory takes the low address bits it needs
	typedef struct packed {
		logic                   wr_en;
		logic [a_addr_bits-1:0] addr;
		elem_t                  data;
	} ram_wr_t;

	// One read request, data follows a cycle later
	typedef struct packed {
		logic                   rd_en;
		logic [a_addr_bits-1:0] addr;
	} ram_rd_t;

	typedef struct packed {
		logic                  tvalid;
		logic [axis_width-1:0] tdata;
	} axis_in_t;

	typedef struct packed {
		logic                  tvalid;
		logic [axis_width-1:0] tdata;
		logic                  tlast;
	} axis_out_t;

endpackage

//--- hw/sample_ram.sv
// Element RAM with one write port and two registered read ports
`timescale 1ns/1ps

module sample_ram #(
	parameter int depth_bits = 9
) (
	input  logic                ACLK,
	input  coproc_pkg::ram_wr_t wr,
	input  coproc_pkg::ram_rd_t rd0,
	input  coproc_pkg::ram_rd_t rd1,
	output coproc_pkg::elem_t   rd_data0,
	output coproc_pkg::elem_t   rd_data1
);
	import coproc_pkg::*;

	// Storage array, contents are don't-care after reset
	elem_t mem [2**depth_bits];

	// Write lands at the edge, visible to a read one cycle later
	always_ff @(posedge ACLK) begin
		if (wr.wr_en) begin
			mem[wr.addr[depth_bits-1:0]] <= wr.data;
		end
	end

	// Read ports hold their last word while the enable is low
	always_ff @(posedge ACLK) begin
		if (rd0.rd_en) begin
			rd_data0 <= mem[rd0.addr[depth_bits-1:0]];
		end
		if (rd1.rd_en) begin
			rd_data1 <= mem[rd1.addr[depth_bits-1:0]];
		end
	end

	// Writer must stay inside this instance's depth
	a_wr_in_range: assert property (@(posedge ACLK)
		wr.wr_en |-> (wr.addr >> depth_bits) == '0);

endmodule

//--- hw/frame_loader.sv
// Input stream loader that splits a frame into the A, B and C memories
`timescale 1ns/1ps

module frame_loader (
	input  logic                 ACLK,
	input  logic                 ARESETN,
	input  coproc_pkg::axis_in_t s_axis,
	output logic                 s_axis_tready,
	input  logic                 frame_sent,
	output coproc_pkg::ram_wr_t  a_wr,
	output coproc_pkg::ram_wr_t  b_wr,
	output coproc_pkg::ram_wr_t  c_wr,
	output logic                 start
);
	import coproc_pkg::*;

	typedef enum logic {
		st_load,
		st_wait
	} state_t;

	state_t state;

	// Position inside the 467-word frame
	logic [$clog2(in_words)-1:0] word_cnt;
	logic [$clog2(in_words)-1:0] wr_idx;
	elem_t                       wr_byte;
	logic                        a_wen;
	logic                        b_wen;
	logic                        c_wen;
	logic                        accept;

	// Ready only depends on state, never on tvalid
	assign s_axis_tready = (state == st_load);
	assign accept        = s_axis.tvalid & s_axis_tready;

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			state    <= st_load;
			word_cnt <= '0;
			a_wen    <= 1'b0;
			b_wen    <= 1'b0;
			c_wen    <= 1'b0;
			start    <= 1'b0;
		end else begin
			// Route by frame position
			a_wen <= accept && (word_cnt < a_words);
			b_wen <= accept && (word_cnt >= a_words) && (word_cnt < a_words + b_words);
			c_wen <= accept && (word_cnt >= a_words + b_words);
			// Kick the engine once the last C word is written
			start <= c_wen && (wr_idx == in_words - 1);
			if (accept) begin
				if (word_cnt == in_words - 1) begin
					word_cnt <= '0;
					state    <= st_wait;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
			// Reopen input once the results have left
			if (state == st_wait && frame_sent) begin
				state <= st_load;
			end
		end
	end

	// Payload, upper 24 bits dropped
	always_ff @(posedge ACLK) begin
		if (accept) begin
			wr_idx  <= word_cnt;
			wr_byte <= s_axis.tdata[data_width-1:0];
		end
	end

	// Addresses rebased to each matrix
	assign a_wr = '{wr_en: a_wen, addr: wr_idx, data: wr_byte};
	assign b_wr = '{wr_en: b_wen, addr: a_addr_bits'(wr_idx - a_words), data: wr_byte};
	assign c_wr = '{wr_en: c_wen, addr: a_addr_bits'(wr_idx - a_words - b_words),
		data: wr_byte};

	a_one_target: assert property (@(posedge ACLK) disable iff (!ARESETN)
		$onehot0({a_wr.wr_en, b_wr.wr_en, c_wr.wr_en}));

endmodule

//--- hw/mlp_engine.sv
// Two-layer fixed-point network engine, one row every 9 cycles
`timescale 1ns/1ps

module mlp_engine (
	input  logic                ACLK,
	input  logic                ARESETN,
	input  logic                start,
	output coproc_pkg::ram_rd_t a_rd,
	output coproc_pkg::ram_rd_t b_rd0,
	output coproc_pkg::ram_rd_t b_rd1,
	output coproc_pkg::ram_rd_t c_rd,
	input  coproc_pkg::elem_t   a_data,
	input  coproc_pkg::elem_t   b_data0,
	input  coproc_pkg::elem_t   b_data1,
	input  coproc_pkg::elem_t   c_data,
	output coproc_pkg::ram_wr_t res_wr,
	output logic                done
);
	import coproc_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_load_c,
		st_run
	} state_t;

	state_t                   state;
	logic [3:0]               phase;
	logic [res_addr_bits-1:0] row;
	logic [a_addr_bits-1:0]   a_ptr;
	logic [c_addr_bits-1:0]   c_cnt;
	logic                     c_cap;
	logic [c_addr_bits-1:0]   c_cap_idx;
	elem_t                    c_reg [c_words];
	elem_t                    b_col [n_hidden];
	logic [acc_width-1:0]     acc [n_hidden];
	logic [acc_width-1:0]     acc_next [n_hidden];
	elem_t                    hidden [n_hidden];
	logic [acc_width-1:0]     out_sum;
	logic                     last_phase;
	logic                     res_wen;
	logic [res_addr_bits-1:0] res_row;
	elem_t                    res_byte;

	// Shift right then clamp to one byte
	function automatic elem_t sat_shift(input logic [acc_width-1:0] v);
		logic [acc_width-1:0] s;
		s = v >> frac_shift;
		if (s > acc_width'({data_width{1'b1}})) begin
			return {data_width{1'b1}};
		end
		return s[data_width-1:0];
	endfunction

	assign b_col[0]   = b_data0;
	assign b_col[1]   = b_data1;
	assign last_phase = (phase == 4'(a_cols + 1));

	// Phase 0 fetches the bias row, phases 1..7 fetch A[r][k] and B row k+1
	assign a_rd  = '{rd_en: state == st_run && phase != 0 && !last_phase, addr: a_ptr};
	assign b_rd0 = '{rd_en: state == st_run && !last_phase,
		addr: a_addr_bits'({phase[2:0], 1'b0})};
	assign b_rd1 = '{rd_en: state == st_run && !last_phase,
		addr: a_addr_bits'({phase[2:0], 1'b1})};
	assign c_rd  = '{rd_en: state == st_load_c, addr: a_addr_bits'(c_cnt)};

	// Last MAC and the output layer fold into the final phase
	always_comb begin
		out_sum = acc_width'(c_reg[0]);
		for (int j = 0; j < n_hidden; j++) begin
			acc_next[j] = acc[j] + acc_width'(a_data) * acc_width'(b_col[j]);
			hidden[j]   = sat_shift(acc_next[j]);
			out_sum     = out_sum + acc_width'(c_reg[j+1]) * acc_width'(hidden[j]);
		end
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			state   <= st_idle;
			phase   <= '0;
			row     <= '0;
			a_ptr   <= '0;
			c_cnt   <= '0;
			c_cap   <= 1'b0;
			res_wen <= 1'b0;
			done    <= 1'b0;
		end else begin
			c_cap   <= (state == st_load_c);
			res_wen <= (state == st_run) && last_phase;
			// Done follows the 64th result write
			done    <= res_wen && (res_row == res_addr_bits'(a_rows - 1));
			if (a_rd.rd_en) begin
				a_ptr <= a_ptr + 1'b1;
			end
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_load_c;
						c_cnt <= '0;
						a_ptr <= '0;
						row   <= '0;
						phase <= '0;
					end
				end
				st_load_c: begin
					c_cnt <= c_cnt + 1'b1;
					if (c_cnt == c_addr_bits'(c_words - 1)) begin
						state <= st_run;
					end
				end
				st_run: begin
					if (last_phase) begin
						phase <= '0;
						row   <= row + 1'b1;
						if (row == res_addr_bits'(a_rows - 1)) begin
							state <= st_idle;
						end
					end else begin
						phase <= phase + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge ACLK) begin
		c_cap_idx <= c_cnt;
		if (c_cap) begin
			c_reg[c_cap_idx] <= c_data;
		end
		if (state == st_run) begin
			for (int j = 0; j < n_hidden; j++) begin
				// Bias lands in phase 1, MACs follow
				acc[j] <= (phase == 4'd1) ? acc_width'(b_col[j]) : acc_next[j];
			end
		end
		if (last_phase) begin
			res_row  <= row;
			res_byte <= sat_shift(out_sum);
		end
	end

	assign res_wr = '{wr_en: res_wen, addr: a_addr_bits'(res_row), data: res_byte};

	a_start_idle: assert property (@(posedge ACLK) disable iff (!ARESETN)
		start |-> state == st_idle);

endmodule

//--- hw/result_streamer.sv
// Result streamer that drains the result memory onto the output stream
`timescale 1ns/1ps

module result_streamer (
	input  logic                  ACLK,
	input  logic                  ARESETN,
	input  logic                  done,
	output coproc_pkg::ram_rd_t   res_rd,
	input  coproc_pkg::elem_t     res_data,
	output coproc_pkg::axis_out_t m_axis,
	input  logic                  m_axis_tready,
	output logic                  frame_sent
);
	import coproc_pkg::*;

	logic                     rd_active;
	logic [res_addr_bits-1:0] rd_cnt;
	logic                     rd_vld;
	logic                     rd_last;
	logic                     out_vld;
	logic                     out_last;
	elem_t                    out_data;
	logic                     out_free;
	logic                     move;
	logic                     issue;

	// Output slot frees on transfer
	assign out_free = !out_vld || m_axis_tready;
	// Read stage shifts into the output register
	assign move     = rd_vld && out_free;
	// Only read when the read stage will be empty
	assign issue    = rd_active && (!rd_vld || move);

	always_ff @(posedge ACLK) begin
		if (!ARESETN) begin
			rd_active <= 1'b0;
			rd_cnt    <= '0;
			rd_vld    <= 1'b0;
			rd_last   <= 1'b0;
			out_vld   <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			if (done) begin
				rd_active <= 1'b1;
				rd_cnt    <= '0;
			end else if (issue) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == res_addr_bits'(out_words - 1)) begin
					rd_active <= 1'b0;
				end
			end
			// RAM output holds while stalled since no read is issued
			if (issue) begin
				rd_vld  <= 1'b1;
				rd_last <= (rd_cnt == res_addr_bits'(out_words - 1));
			end else if (move) begin
				rd_vld <= 1'b0;
			end
			if (move) begin
				out_vld  <= 1'b1;
				out_last <= rd_last;
			end else if (m_axis_tready) begin
				out_vld  <= 1'b0;
				out_last <= 1'b0;
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (move) begin
			out_data <= res_data;
		end
	end

	assign res_rd     = '{rd_en: issue, addr: a_addr_bits'(rd_cnt)};
	assign m_axis     = '{tvalid: out_vld,
		tdata: {{(axis_width - data_width){1'b0}}, out_data}, tlast: out_last};
	// Pulses on the tlast transfer
	assign frame_sent = out_vld && m_axis_tready && out_last;

	a_hold_stall: assert property (@(posedge ACLK) disable iff (!ARESETN)
		m_axis.tvalid && !m_axis_tready |=>
		m_axis.tvalid && $stable(m_axis.tdata) && $stable(m_axis.tlast));

endmodule

//--- hw/mlp_coproc.sv
// Coprocessor top with stream ports, memories, loader, engine and streamer
`timescale 1ns/1ps

module mlp_coproc (
	input  logic                  ACLK,
	input  logic                  ARESETN,
	input  coproc_pkg::axis_in_t  s_axis,
	output logic                  s_axis_tready,
	output coproc_pkg::axis_out_t m_axis,
	input  logic                  m_axis_tready
);
	import coproc_pkg::*;

	// Write requests
	ram_wr_t a_wr;
	ram_wr_t b_wr;
	ram_wr_t c_wr;
	ram_wr_t res_wr;

	// Read requests
	ram_rd_t a_rd;
	ram_rd_t b_rd0;
	ram_rd_t b_rd1;
	ram_rd_t c_rd;
	ram_rd_t res_rd;

	// Read data
	elem_t a_data;
	elem_t b_data0;
	elem_t b_data1;
	elem_t c_data;
	elem_t res_data;

	// Phase handshakes
	logic start;
	logic done;
	logic frame_sent;

	sample_ram #(.depth_bits(a_addr_bits)) a_ram (
		.ACLK(ACLK), .wr(a_wr), .rd0(a_rd), .rd1('0),
		.rd_data0(a_data), .rd_data1()
	);

	// B needs both ports for the two hidden columns
	sample_ram #(.depth_bits(b_addr_bits)) b_ram (
		.ACLK(ACLK), .wr(b_wr), .rd0(b_rd0), .rd1(b_rd1),
		.rd_data0(b_data0), .rd_data1(b_data1)
	);

	sample_ram #(.depth_bits(c_addr_bits)) c_ram (
		.ACLK(ACLK), .wr(c_wr), .rd0(c_rd), .rd1('0),
		.rd_data0(c_data), .rd_data1()
	);

	sample_ram #(.depth_bits(res_addr_bits)) res_ram (
		.ACLK(ACLK), .wr(res_wr), .rd0(res_rd), .rd1('0),
		.rd_data0(res_data), .rd_data1()
	);

	frame_loader loader (
		.ACLK(ACLK), .ARESETN(ARESETN), .s_axis(s_axis), .s_axis_tready(s_axis_tready),
		.frame_sent(frame_sent), .a_wr(a_wr), .b_wr(b_wr), .c_wr(c_wr), .start(start)
	);

	mlp_engine engine (
		.ACLK(ACLK), .ARESETN(ARESETN), .start(start),
		.a_rd(a_rd), .b_rd0(b_rd0), .b_rd1(b_rd1), .c_rd(c_rd),
		.a_data(a_data), .b_data0(b_data0), .b_data1(b_data1), .c_data(c_data),
		.res_wr(res_wr), .done(done)
	);

	result_streamer streamer (
		.ACLK(ACLK), .ARESETN(ARESETN), .done(done), .res_rd(res_rd),
		.res_data(res_data), .m_axis(m_axis), .m_axis_tready(m_axis_tready),
		.frame_sent(frame_sent)
	);

endmodule

//--- test/tb_ref_model.svh
// Reference network model giving one expected output byte per row of the frame buffer
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Hidden unit j of row r, bias plus seven products, then shift and clamp
function automatic int unsigned hidden_value(input int r, input int j);
	int unsigned sum;
	int unsigned a_val;
	int unsigned b_val;
	int k;
	// B row 0 holds the biases
	sum = frame_byte[a_words + j];
	for (k = 0; k < a_cols; k++) begin
		a_val = frame_byte[r * a_cols + k];
		// B row k+1, column j
		b_val = frame_byte[a_words + 2 * (k + 1) + j];
		sum   = sum + a_val * b_val;
	end
	sum = sum >> frac_shift;
	if (sum > 255) begin
		sum = 255;
	end
	return sum;
endfunction

// Output layer for row r
function automatic elem_t expected_output(input int r);
	int unsigned c0;
	int unsigned c1;
	int unsigned c2;
	int unsigned sum;
	c0  = frame_byte[a_words + b_words];
	c1  = frame_byte[a_words + b_words + 1];
	c2  = frame_byte[a_words + b_words + 2];
	sum = c0 + c1 * hidden_value(r, 0) + c2 * hidden_value(r, 1);
	sum = sum >> frac_shift;
	// Clamp to one byte
	if (sum > 255) begin
		sum = 255;
	end
	return elem_t'(sum);
endfunction

`endif

//--- test/tb_mlp_coproc.sv
// Testbench for the coprocessor with stream drivers, output monitor and watchdog
`timescale 1ns/1ps

module tb_mlp_coproc;
	import coproc_pkg::*;

	localparam int clk_period  = 20;
	// Seven frames over five tests
	localparam int num_frames  = 7;
	localparam int fill_random = 0;
	localparam int fill_ones   = 1;
	localparam int fill_zero   = 2;

	logic      ACLK;
	logic      ARESETN;
	axis_in_t  s_axis;
	logic      s_axis_tready;
	axis_out_t m_axis;
	logic      m_axis_tready;

	// Frame under test and its expected results
	elem_t  frame_byte [in_words];
	elem_t  exp_bytes [out_words];
	integer seed = 32'h341f_05ae;
	int     stall_pct = 0;
	int     err_cnt = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	// Monitor state
	int     in_cnt = 0;
	int     out_idx = 0;
	int     frames_done = 0;
	bit     load_closed = 1'b0;
	bit     rise_due = 1'b0;

	`include "tb_ref_model.svh"

	mlp_coproc mlp_coproc_inst (
		.ACLK(ACLK), .ARESETN(ARESETN), .s_axis(s_axis), .s_axis_tready(s_axis_tready),
		.m_axis(m_axis), .m_axis_tready(m_axis_tready)
	);

	initial begin
		ACLK = 1'b0;
		forever #(clk_period / 2) ACLK = ~ACLK;
	end

	// True with the given percent chance
	function automatic bit roll_percent(input int pct);
		logic [31:0] r;
		r = $random(seed);
		return (r % 100) < pct;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			err_cnt++;
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	// Random frame, B kept small so hidden values mostly stay below saturation
	task automatic fill_frame(input int mode);
		logic [31:0] rnd;
		for (int i = 0; i < in_words; i++) begin
			rnd = $random(seed);
			case (mode)
				fill_ones: frame_byte[i] = 8'hff;
				fill_zero: frame_byte[i] = 8'h00;
				default: begin
					frame_byte[i] = rnd[7:0];
					if (i >= a_words && i < a_words + b_words) begin
						frame_byte[i] = rnd[7:0] & 8'h3f;
					end
				end
			endcase
		end
	endtask

	// Drive one frame, random junk in the upper 24 bits
	task automatic send_frame(input int gap_pct);
		logic [31:0] rnd;
		int          idx;
		idx = 0;
		while (idx < in_words) begin
			@(negedge ACLK);
			rnd           = $random(seed);
			s_axis.tvalid = !roll_percent(gap_pct);
			s_axis.tdata  = {rnd[31:8], frame_byte[idx]};
			@(posedge ACLK);
			if (s_axis.tvalid && s_axis_tready) begin
				idx++;
			end
		end
		@(negedge ACLK);
		s_axis.tvalid = 1'b0;
	endtask

	// Load expectations, send, then wait for the tlast transfer
	task automatic run_frame(input int mode, input int gap_pct);
		int target;
		fill_frame(mode);
		for (int r = 0; r < out_words; r++) begin
			exp_bytes[r] = expected_output(r);
		end
		target = frames_done + 1;
		send_frame(gap_pct);
		while (frames_done < target) begin
			@(posedge ACLK);
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", num, name, err_cnt - errs_before);
		end
	endtask

	// Output back-pressure, redrawn every falling edge
	initial begin
		m_axis_tready = 1'b0;
		forever begin
			@(negedge ACLK);
			m_axis_tready = !roll_percent(stall_pct);
		end
	end

	// Compare process on the rising edge
	always @(posedge ACLK) begin
		if (ARESETN) begin
			// Input reopens right after the tlast transfer
			if (rise_due) begin
				check_value("s_axis_tready", 32'd1, 32'(s_axis_tready));
				rise_due = 1'b0;
			end
			if (load_closed) begin
				check_value("s_axis_tready", 32'd0, 32'(s_axis_tready));
			end
			if (s_axis.tvalid && s_axis_tready) begin
				if (in_cnt == in_words - 1) begin
					in_cnt      = 0;
					load_closed = 1'b1;
				end else begin
					in_cnt++;
				end
			end
			if (m_axis.tvalid && m_axis_tready) begin
				if (!load_closed) begin
					err_cnt++;
					$display("Output word sent at %0t while no frame was pending", $time);
				end
				check_value("m_axis.tdata", 32'(exp_bytes[out_idx]), m_axis.tdata);
				check_value("m_axis.tlast", 32'(out_idx == out_words - 1), 32'(m_axis.tlast));
				if (out_idx == out_words - 1) begin
					out_idx     = 0;
					frames_done++;
					load_closed = 1'b0;
					rise_due    = 1'b1;
				end else begin
					out_idx++;
				end
			end
		end
	end

	// Watchdog, 2000 cycles per frame
	initial begin
		#(num_frames * 2000 * clk_period);
		$display("Timeout: the expected results did not all arrive in time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int errs_before;
		ARESETN = 1'b0;
		s_axis  = '0;
		repeat (3) @(negedge ACLK);
		ARESETN = 1'b1;

		errs_before = err_cnt;
		@(posedge ACLK);
		check_value("m_axis.tvalid", 32'd0, 32'(m_axis.tvalid));
		check_value("s_axis_tready", 32'd1, 32'(s_axis_tready));
		run_frame(fill_random, 0);
		report_test(1, "back-to-back frame", errs_before);

		errs_before = err_cnt;
		run_frame(fill_random, 30);
		report_test(2, "input gaps", errs_before);

		errs_before = err_cnt;
		stall_pct   = 40;
		run_frame(fill_random, 0);
		stall_pct   = 0;
		report_test(3, "output back-pressure", errs_before);

		// Two frames in a row, tready window checked by the monitor
		errs_before = err_cnt;
		stall_pct   = 20;
		run_frame(fill_random, 10);
		run_frame(fill_random, 10);
		stall_pct   = 0;
		report_test(4, "tlast and second frame", errs_before);

		errs_before = err_cnt;
		run_frame(fill_ones, 0);
		run_frame(fill_zero, 0);
		report_test(5, "saturation and zero", errs_before);

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- mlp_coproc.f
+incdir+test
hw/coproc_pkg.sv
hw/sample_ram.sv
hw/frame_loader.sv
hw/mlp_engine.sv
hw/result_streamer.sv
hw/mlp_coproc.sv
test/tb_mlp_coproc.sv

//--- Bender.yml
package:
  name: mlp_coproc

sources:
  - files:
      - hw/coproc_pkg.sv
      - hw/sample_ram.sv
      - hw/frame_loader.sv
      - hw/mlp_engine.sv
      - hw/result_streamer.sv
      - hw/mlp_coproc.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mlp_coproc.sv
